// ==== verilog.f ====
verilog/apb1_pkg.sv
verilog/apb_if.sv
verilog/ahb_apb_bridge.sv
verilog/apb_slot_decoder.sv
verilog/apb_timer.sv
verilog/apb_scratch_regs.sv
verilog/apb1_sub_top.sv
verification/tb_apb1_sub_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the APB1 subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_apb1_sub_top \
  -f verilog.f -Mdir obj_dir -o vsim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/vsim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Simulation PASSED$" sim.log; then
  exit 0
fi
exit 1

// ==== verification/tb_apb1_sub_top.sv ====
//////////////////////////////////////////////////////////////////////
// AHB master driving one transfer at a time; external slaves modeled
// as zero wait state with data = slot * 0x1111_0000 + offset
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_apb1_sub_top
  import apb1_pkg::*;
;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_WAIT} op_e;

  typedef struct packed {
    op_e               op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic              err;
    logic              chk_irq;
    logic [2:0]        irq; // {scratch_intr, tim_intr}
  } row_t;

  logic              hclk;
  logic              rst;
  logic              hsel;
  logic [ADDR_W-1:0] haddr;
  logic [1:0]        htrans;
  logic              hwrite;
  logic [DATA_W-1:0] hwdata;
  logic [DATA_W-1:0] hrdata;
  logic              hready;
  logic              hresp;
  logic [ADDR_W-1:0] apb1_xx_paddr;
  logic              apb1_xx_penable;
  logic              apb1_xx_pwrite;
  logic [DATA_W-1:0] apb1_xx_pwdata;
  logic              gpio_psel;
  logic              rtc_psel;
  logic              pmu_psel;
  logic [DATA_W-1:0] gpio_prdata;
  logic [DATA_W-1:0] rtc_prdata;
  logic [DATA_W-1:0] pmu_prdata;
  logic [1:0]        tim_intr;
  logic              scratch_intr;

  row_t              rows [0:63];
  int                n_rows;
  int                cyc_count;
  int                cyc_limit = 400;
  int                gpio_hits;
  int                rtc_hits;
  int                pmu_hits;
  logic [DATA_W-1:0] ext_pwdata;
  logic [ADDR_W-1:0] ext_paddr;
  logic              ext_pwrite;

  apb1_sub_top u_dut (.*);

  initial hclk = 1'b0;
  always #2 hclk = ~hclk;

  function automatic logic [DATA_W-1:0] ext_word(input logic [SLOT_W-1:0] slot,
                                                  input logic [OFFS_W-1:0] offs);
    ext_word = DATA_W'(slot) * 32'h1111_0000 + DATA_W'(offs);
  endfunction

  function automatic logic [2:0] ext_mask(input logic [ADDR_W-1:0] addr);
    case (addr[15:12])
      4'd5:    ext_mask = 3'b001;
      4'd6:    ext_mask = 3'b010;
      4'd15:   ext_mask = 3'b100;
      default: ext_mask = 3'b000;
    endcase
  endfunction

  assign gpio_prdata = gpio_psel ? ext_word(4'd5, apb1_xx_paddr[11:0]) : '0;
  assign rtc_prdata  = rtc_psel ? ext_word(4'd6, apb1_xx_paddr[11:0]) : '0;
  assign pmu_prdata  = pmu_psel ? ext_word(4'd15, apb1_xx_paddr[11:0]) : '0;

  // sampled mid cycle between clock edges
  always @(negedge hclk) begin
    if (gpio_psel)
      gpio_hits = gpio_hits + 1;
    if (rtc_psel)
      rtc_hits = rtc_hits + 1;
    if (pmu_psel)
      pmu_hits = pmu_hits + 1;
    if (apb1_xx_penable && (gpio_psel || rtc_psel || pmu_psel)) begin
      ext_pwdata = apb1_xx_pwdata;
      ext_paddr  = apb1_xx_paddr;
      ext_pwrite = apb1_xx_pwrite;
    end
  end

  always @(posedge hclk) begin
    cyc_count = cyc_count + 1;
    if (cyc_count >= cyc_limit) begin
      $display("timeout: the test did not finish within %0d cycles", cyc_limit);
      $display("Simulation FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s: got %h, expected %h", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_resp(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s: hresp %b, expected %b", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "response mismatch");
    end
  endtask

  task automatic add_row(input op_e op, input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] rdata,
                         input logic err, input logic chk_irq, input logic [2:0] irq);
    rows[n_rows] = '{op, addr, wdata, rdata, err, chk_irq, irq};
    n_rows++;
  endtask

  // address phase, then data phase until hready returns
  task automatic ahb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata,
                          output logic resp_low, output logic resp_last, output int low);
    low      = 0;
    resp_low = HRESP_OKAY;
    hsel     = 1'b1;
    htrans   = HTRANS_NONSEQ;
    haddr    = addr;
    hwrite   = wr;
    @(posedge hclk);
    #1;
    hsel   = 1'b0;
    htrans = 2'b00;
    hwdata = wdata;
    while (!hready) begin
      low++;
      resp_low = hresp;
      @(posedge hclk);
      #1;
    end
    rdata     = hrdata;
    resp_last = hresp;
  endtask

  initial begin
    logic [DATA_W-1:0] rnd_a;
    logic [DATA_W-1:0] rnd_b;
    logic [DATA_W-1:0] rdata;
    logic              resp_low;
    logic              resp_last;
    logic [2:0]        mask;
    int                low;
    int                g0;
    int                r0;
    int                p0;

    rst = 1'b1;
    hsel = 1'b0;
    haddr = '0;
    htrans = 2'b00;
    hwrite = 1'b0;
    hwdata = '0;
    n_rows = 0;
    cyc_count = 0;
    gpio_hits = 0;
    rtc_hits = 0;
    pmu_hits = 0;
    ext_pwdata = '0;
    ext_paddr = '0;
    ext_pwrite = 1'b0;
    void'($urandom(32'h64c5_dd2b));
    rnd_a = $urandom();
    rnd_b = $urandom();

    add_row(OP_WR, 32'h0000_1000, rnd_a, '0, 1'b0, 1'b1, 3'b000);
    add_row(OP_RD, 32'h0000_1000, '0, rnd_a, 1'b0, 1'b0, 3'b000);
    add_row(OP_WR, 32'h0000_1000, rnd_b, '0, 1'b0, 1'b0, 3'b000);
    add_row(OP_RD, 32'h0000_1000, '0, rnd_b, 1'b0, 1'b0, 3'b000);
    add_row(OP_WR, 32'h0000_1004, 32'h1, '0, 1'b0, 1'b1, 3'b100);
    add_row(OP_RD, 32'h0000_1004, '0, 32'h1, 1'b0, 1'b1, 3'b100);
    add_row(OP_WR, 32'h0000_1004, 32'h0, '0, 1'b0, 1'b1, 3'b000);
    add_row(OP_RD, 32'h0000_1004, '0, 32'h0, 1'b0, 1'b1, 3'b000);
    add_row(OP_WR, 32'h0000_0000, 32'd20, '0, 1'b0, 1'b0, 3'b000); // ch0 load
    add_row(OP_WR, 32'h0000_0004, 32'h3, '0, 1'b0, 1'b1, 3'b000);  // enable + ie
    add_row(OP_WAIT, '0, '0, '0, 1'b0, 1'b1, 3'b001);
    add_row(OP_RD, 32'h0000_000c, '0, 32'h1, 1'b0, 1'b1, 3'b001);
    add_row(OP_WR, 32'h0000_000c, 32'h1, '0, 1'b0, 1'b1, 3'b000);
    add_row(OP_WR, 32'h0000_0004, 32'h0, '0, 1'b0, 1'b1, 3'b000);
    add_row(OP_RD, 32'h0000_001c, '0, 32'h0, 1'b0, 1'b1, 3'b000);  // ch1 quiet
    add_row(OP_RD, 32'h0000_0018, '0, 32'h0, 1'b0, 1'b1, 3'b000);
    add_row(OP_RD, 32'h0000_5000, '0, ext_word(4'd5, 12'h000), 1'b0, 1'b0, 3'b000);
    add_row(OP_RD, 32'h0000_6008, '0, ext_word(4'd6, 12'h008), 1'b0, 1'b0, 3'b000);
    add_row(OP_RD, 32'h0000_f3fc, '0, ext_word(4'd15, 12'h3fc), 1'b0, 1'b0, 3'b000);
    add_row(OP_WR, 32'h0000_5010, 32'hcafe_0005, '0, 1'b0, 1'b0, 3'b000);
    add_row(OP_WR, 32'h0000_6020, 32'h0bad_0006, '0, 1'b0, 1'b0, 3'b000);
    add_row(OP_WR, 32'h0000_f004, 32'h1234_000f, '0, 1'b0, 1'b0, 3'b000);
    add_row(OP_RD, 32'h0000_3000, '0, 32'h0, 1'b1, 1'b0, 3'b000);  // unmapped
    add_row(OP_WR, 32'h0000_3004, 32'hdead_beef, '0, 1'b1, 1'b0, 3'b000);
    add_row(OP_RD, 32'h0000_1000, '0, rnd_b, 1'b0, 1'b1, 3'b000);
    cyc_limit = n_rows * 8 + 400;

    repeat (5) @(posedge hclk);
    #1;
    rst = 1'b0;

    for (int i = 0; i < n_rows; i++) begin
      if (rows[i].op == OP_WAIT) begin
        for (int k = 0; k < 25 && !tim_intr[0]; k++) begin
          @(posedge hclk);
          #1;
        end
        check_data(DATA_W'(tim_intr[0]), 32'h1, "tim_intr[0] within 25 cycles");
      end else begin
        g0 = gpio_hits;
        r0 = rtc_hits;
        p0 = pmu_hits;
        ahb_xfer(rows[i].op == OP_WR, rows[i].addr, rows[i].wdata, rdata,
                 resp_low, resp_last, low);
        check_data(DATA_W'(low), rows[i].err ? 32'd3 : 32'd2, "hready low cycles");
        check_resp(resp_low, rows[i].err, "response before hready");
        check_resp(resp_last, rows[i].err, "response with hready");
        if (rows[i].op == OP_RD)
          check_data(rdata, rows[i].rdata, "read data");
        mask = {pmu_hits != p0, rtc_hits != r0, gpio_hits != g0};
        check_data(DATA_W'(mask), DATA_W'(ext_mask(rows[i].addr)), "external selects");
        if (mask != 3'b000) begin
          check_data(ext_paddr, rows[i].addr, "external address");
          check_data(DATA_W'(ext_pwrite), DATA_W'(rows[i].op == OP_WR), "external direction");
        end
        if (rows[i].op == OP_WR && mask != 3'b000)
          check_data(ext_pwdata, rows[i].wdata, "external write data");
      end
      if (rows[i].chk_irq)
        check_data(DATA_W'({scratch_intr, tim_intr}), DATA_W'(rows[i].irq), "interrupts");
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== verilog/apb1_sub_top.sv ====
//////////////////////////////////////////////////////////////////////
// single clock hclk, sync reset; gpio, rtc and pmu sit outside on
// the shared apb1_xx bus and must be zero wait state, error free
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module apb1_sub_top
  import apb1_pkg::*;
(
  input  logic              hclk,
  input  logic              rst,
  input  logic              hsel,
  input  logic [ADDR_W-1:0] haddr,
  input  logic [1:0]        htrans,
  input  logic              hwrite,
  input  logic [DATA_W-1:0] hwdata,
  output logic [DATA_W-1:0] hrdata,
  output logic              hready,
  output logic              hresp,
  output logic [ADDR_W-1:0] apb1_xx_paddr,
  output logic              apb1_xx_penable,
  output logic              apb1_xx_pwrite,
  output logic [DATA_W-1:0] apb1_xx_pwdata,
  output logic              gpio_psel,
  output logic              rtc_psel,
  output logic              pmu_psel,
  input  logic [DATA_W-1:0] gpio_prdata,
  input  logic [DATA_W-1:0] rtc_prdata,
  input  logic [DATA_W-1:0] pmu_prdata,
  output logic [1:0]        tim_intr,
  output logic              scratch_intr
);

  apb_if #(.AW(ADDR_W), .DW(DATA_W)) br_bus  ();
  apb_if #(.AW(ADDR_W), .DW(DATA_W)) tim_bus ();
  apb_if #(.AW(ADDR_W), .DW(DATA_W)) scr_bus ();

  ahb_apb_bridge u_bridge (
    .hclk   (hclk),
    .rst    (rst),
    .hsel   (hsel),
    .haddr  (haddr),
    .htrans (htrans),
    .hwrite (hwrite),
    .hwdata (hwdata),
    .hrdata (hrdata),
    .hready (hready),
    .hresp  (hresp),
    .apb    (br_bus.master)
  );

  apb_slot_decoder u_decoder (
    .up          (br_bus.slave),
    .tim         (tim_bus.master),
    .scr         (scr_bus.master),
    .gpio_psel   (gpio_psel),
    .rtc_psel    (rtc_psel),
    .pmu_psel    (pmu_psel),
    .gpio_prdata (gpio_prdata),
    .rtc_prdata  (rtc_prdata),
    .pmu_prdata  (pmu_prdata)
  );

  apb_timer u_timer (
    .hclk (hclk),
    .rst  (rst),
    .bus  (tim_bus.slave),
    .intr (tim_intr)
  );

  apb_scratch_regs u_scratch (
    .hclk (hclk),
    .rst  (rst),
    .bus  (scr_bus.slave),
    .intr (scratch_intr)
  );

  // shared outside bus, qualified by the per-slot selects
  assign apb1_xx_paddr   = br_bus.paddr;
  assign apb1_xx_penable = br_bus.penable;
  assign apb1_xx_pwrite  = br_bus.pwrite;
  assign apb1_xx_pwdata  = br_bus.pwdata;

endmodule

// ==== verilog/apb_scratch_regs.sv ====
//////////////////////////////////////////////////////////////////////
// scratch word plus a pending flag set and cleared by software
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module apb_scratch_regs
  import apb1_pkg::*;
(
  input  logic hclk,
  input  logic rst,
  apb_if.slave bus,
  output logic intr
);

  apb_addr_u         addr;
  logic              wr;
  logic [DATA_W-1:0] data_q;
  logic              pend_q;

  assign addr.raw = bus.paddr;
  assign wr       = bus.psel && bus.penable && bus.pwrite;

  always_ff @(posedge hclk) begin
    if (rst) begin
      data_q <= '0;
      pend_q <= 1'b0;
    end else if (wr) begin
      if (addr.fld.offs == SCR_DATA)
        data_q <= bus.pwdata;
      if (addr.fld.offs == SCR_INTR)
        pend_q <= bus.pwdata[0]; // software sets and clears directly
    end
  end

  always_comb begin
    bus.prdata = '0;
    if (addr.fld.offs == SCR_DATA)
      bus.prdata = data_q;
    else if (addr.fld.offs == SCR_INTR)
      bus.prdata[0] = pend_q;
  end

  assign bus.pready  = 1'b1;
  assign bus.pslverr = 1'b0;
  assign intr        = pend_q;

endmodule

// ==== verilog/apb_timer.sv ====
//////////////////////////////////////////////////////////////////////
// two reloading down counters, period is load + 1 cycles
// TIM_VALUE is read only; offsets past channel 1 read zero
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module apb_timer
  import apb1_pkg::*;
(
  input  logic       hclk,
  input  logic       rst,
  apb_if.slave       bus,
  output logic [1:0] intr
);

  apb_addr_u                addr;
  logic                     ch;
  logic                     hit;
  logic [OFFS_W-1:0]        roff;
  logic                     wr;
  logic [1:0][DATA_W-1:0]   ch_rdata;

  assign addr.raw = bus.paddr;
  assign ch       = (addr.fld.offs >= TIM_CH_STRIDE);
  assign hit      = (addr.fld.offs < (TIM_CH_STRIDE << 1));
  assign roff     = ch ? addr.fld.offs - TIM_CH_STRIDE : addr.fld.offs;
  assign wr       = bus.psel && bus.penable && bus.pwrite;

  for (genvar c = 0; c < 2; c++) begin : g_ch
    logic [DATA_W-1:0] load_q;
    logic [DATA_W-1:0] cnt_q;
    logic [1:0]        ctrl_q;
    logic              stat_q;
    logic              wr_ch;
    logic              wrap;

    assign wr_ch = wr && hit && (ch == 1'(c));
    assign wrap  = ctrl_q[CTRL_EN_BIT] && (cnt_q == '0);

    always_ff @(posedge hclk) begin
      if (rst) begin
        load_q <= '0;
        cnt_q  <= '0;
        ctrl_q <= '0;
        stat_q <= 1'b0;
      end else begin
        if (wr_ch && roff == TIM_LOAD)
          load_q <= bus.pwdata;
        if (wr_ch && roff == TIM_CTRL) begin
          ctrl_q[CTRL_EN_BIT] <= bus.pwdata[CTRL_EN_BIT];
          ctrl_q[CTRL_IE_BIT] <= bus.pwdata[CTRL_IE_BIT];
        end
        if (wr_ch && roff == TIM_LOAD)
          cnt_q <= bus.pwdata; // new load restarts the count
        else if (wrap)
          cnt_q <= load_q;
        else if (ctrl_q[CTRL_EN_BIT])
          cnt_q <= cnt_q - 1'b1;
        if (wrap)
          stat_q <= 1'b1; // wins over a clear in the same cycle
        else if (wr_ch && roff == TIM_STATUS && bus.pwdata[0])
          stat_q <= 1'b0;
      end
    end

    assign ch_rdata[c] = (roff == TIM_LOAD)   ? load_q :
                         (roff == TIM_CTRL)   ? {{(DATA_W-2){1'b0}}, ctrl_q} :
                         (roff == TIM_VALUE)  ? cnt_q :
                         (roff == TIM_STATUS) ? {{(DATA_W-1){1'b0}}, stat_q} : '0;

    assign intr[c] = stat_q & ctrl_q[CTRL_IE_BIT];
  end

  assign bus.prdata  = hit ? ch_rdata[ch] : '0;
  assign bus.pready  = 1'b1;
  assign bus.pslverr = 1'b0;

endmodule

// ==== verilog/apb_slot_decoder.sv ====
//////////////////////////////////////////////////////////////////////
// external slots are taken as always ready and error free
// unmapped slots answer with pslverr and zero data
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module apb_slot_decoder
  import apb1_pkg::*;
(
  apb_if.slave              up,
  apb_if.master             tim,
  apb_if.master             scr,
  output logic              gpio_psel,
  output logic              rtc_psel,
  output logic              pmu_psel,
  input  logic [DATA_W-1:0] gpio_prdata,
  input  logic [DATA_W-1:0] rtc_prdata,
  input  logic [DATA_W-1:0] pmu_prdata
);

  apb_addr_u         addr;
  logic [SLOT_W-1:0] slot;

  assign addr.raw = up.paddr;
  assign slot     = addr.fld.slot;

  assign tim.psel  = up.psel && (slot == SLOT_TIMER);
  assign scr.psel  = up.psel && (slot == SLOT_SCRATCH);
  assign gpio_psel = up.psel && (slot == SLOT_GPIO);
  assign rtc_psel  = up.psel && (slot == SLOT_RTC);
  assign pmu_psel  = up.psel && (slot == SLOT_PMU);

  assign tim.paddr   = up.paddr;
  assign tim.penable = up.penable;
  assign tim.pwrite  = up.pwrite;
  assign tim.pwdata  = up.pwdata;
  assign scr.paddr   = up.paddr;
  assign scr.penable = up.penable;
  assign scr.pwrite  = up.pwrite;
  assign scr.pwdata  = up.pwdata;

  always_comb begin
    up.prdata  = '0;
    up.pready  = 1'b1;
    up.pslverr = 1'b0;
    case (slot)
      SLOT_TIMER: begin
        up.prdata  = tim.prdata;
        up.pready  = tim.pready;
        up.pslverr = tim.pslverr;
      end
      SLOT_SCRATCH: begin
        up.prdata  = scr.prdata;
        up.pready  = scr.pready;
        up.pslverr = scr.pslverr;
      end
      SLOT_GPIO: up.prdata = gpio_prdata;
      SLOT_RTC:  up.prdata = rtc_prdata;
      SLOT_PMU:  up.prdata = pmu_prdata;
      default:   up.pslverr = up.psel & up.penable; // nothing behind this slot
    endcase
  end

endmodule

// ==== verilog/ahb_apb_bridge.sv ====
//////////////////////////////////////////////////////////////////////
// one AHB transfer in flight, no hreadyin; hready is the own hreadyout
// error response takes two cycles as AHB-Lite requires
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ahb_apb_bridge
  import apb1_pkg::*;
(
  input  logic              hclk,
  input  logic              rst,
  input  logic              hsel,
  input  logic [ADDR_W-1:0] haddr,
  input  logic [1:0]        htrans,
  input  logic              hwrite,
  input  logic [DATA_W-1:0] hwdata,
  output logic [DATA_W-1:0] hrdata,
  output logic              hready,
  output logic              hresp,
  apb_if.master             apb
);

  logic              setup_q;
  logic              access_q;
  logic              err_q;
  logic              hready_q;
  logic              hresp_q;
  logic [ADDR_W-1:0] paddr_q;
  logic              pwrite_q;
  logic [DATA_W-1:0] pwdata_q;
  logic [DATA_W-1:0] hrdata_q;
  logic              accept;
  logic              done;

  // hready_q is only high while idle
  assign accept = hsel && (|(htrans & HTRANS_NONSEQ)) && hready_q;
  assign done   = access_q && apb.pready;

  always_ff @(posedge hclk) begin
    if (rst) begin
      setup_q  <= 1'b0;
      access_q <= 1'b0;
      err_q    <= 1'b0;
      hready_q <= 1'b1;
      hresp_q  <= HRESP_OKAY;
    end else if (err_q) begin
      err_q    <= 1'b0; // second error cycle
      hready_q <= 1'b1;
    end else if (access_q) begin
      if (apb.pready) begin
        access_q <= 1'b0;
        if (apb.pslverr) begin
          err_q   <= 1'b1;
          hresp_q <= HRESP_ERROR;
        end else begin
          hready_q <= 1'b1;
        end
      end
    end else if (setup_q) begin
      setup_q  <= 1'b0;
      access_q <= 1'b1;
    end else begin
      hresp_q <= HRESP_OKAY;
      if (accept) begin
        setup_q  <= 1'b1;
        hready_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge hclk) begin
    if (accept) begin
      paddr_q  <= haddr;
      pwrite_q <= hwrite;
    end
    if (setup_q)
      pwdata_q <= hwdata; // data phase of the accepted transfer
    if (done)
      hrdata_q <= apb.pslverr ? '0 : apb.prdata;
  end

  assign apb.paddr   = paddr_q;
  assign apb.pwrite  = pwrite_q;
  assign apb.psel    = setup_q | access_q;
  assign apb.penable = access_q;
  assign apb.pwdata  = setup_q ? hwdata : pwdata_q;

  assign hrdata = hrdata_q;
  assign hready = hready_q;
  assign hresp  = hresp_q;

endmodule

// ==== verilog/apb_if.sv ====
//////////////////////////////////////////////////////////////////////
// APB3 signal set without pprot and pstrb
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface apb_if #(
  parameter int AW = 32,
  parameter int DW = 32
);
  logic [AW-1:0] paddr;
  logic          psel;
  logic          penable;
  logic          pwrite;
  logic [DW-1:0] pwdata;
  logic [DW-1:0] prdata;
  logic          pready;
  logic          pslverr;

  modport master (
    output paddr, psel, penable, pwrite, pwdata,
    input  prdata, pready, pslverr
  );

  modport slave (
    input  paddr, psel, penable, pwrite, pwdata,
    output prdata, pready, pslverr
  );
endinterface

// ==== verilog/apb1_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// 16 APB windows of 4 KB each, with the slot in paddr[15:12]
// only 32-bit single transfers are supported on the AHB side
//////////////////////////////////////////////////////////////////////
package apb1_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SLOT_W = 4;
  localparam int OFFS_W = 12;

  // slot map
  localparam logic [SLOT_W-1:0] SLOT_TIMER   = 4'd0;
  localparam logic [SLOT_W-1:0] SLOT_SCRATCH = 4'd1;
  localparam logic [SLOT_W-1:0] SLOT_GPIO    = 4'd5;
  localparam logic [SLOT_W-1:0] SLOT_RTC     = 4'd6;
  localparam logic [SLOT_W-1:0] SLOT_PMU     = 4'd15;

  // timer channel registers, channel 1 at +TIM_CH_STRIDE
  localparam logic [OFFS_W-1:0] TIM_LOAD      = 12'h000;
  localparam logic [OFFS_W-1:0] TIM_CTRL      = 12'h004;
  localparam logic [OFFS_W-1:0] TIM_VALUE     = 12'h008;
  localparam logic [OFFS_W-1:0] TIM_STATUS    = 12'h00c;
  localparam logic [OFFS_W-1:0] TIM_CH_STRIDE = 12'h010;

  localparam logic [OFFS_W-1:0] SCR_DATA = 12'h000;
  localparam logic [OFFS_W-1:0] SCR_INTR = 12'h004;

  localparam int CTRL_EN_BIT = 0;
  localparam int CTRL_IE_BIT = 1;

  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic       HRESP_OKAY    = 1'b0;
  localparam logic       HRESP_ERROR   = 1'b1;

  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [ADDR_W-SLOT_W-OFFS_W-1:0] upper;
      logic [SLOT_W-1:0]               slot;
      logic [OFFS_W-1:0]               offs;
    } fld;
  } apb_addr_u;

endpackage
